/* Makefile */
TOP = rename_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f rename.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

/* hw/free_list.sv */
`timescale 1ns/10ps

module free_list import rename_pkg::*; #(
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                    clk,
    input  logic                    i_rst,

    input  logic [RENAME_WIDTH-1:0] i_rename_vld,
    input  logic [RENAME_WIDTH-1:0] i_has_rd,
    input  logic [RENAME_WIDTH-1:0] i_ismv,
    input  logic                    i_squash_vld,

    input  logic [COMMIT_WIDTH-1:0] i_commit_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_has_rd,
    input  logic [COMMIT_WIDTH-1:0] i_commit_ismv,

    input  logic [COMMIT_WIDTH-1:0] i_dealloc_vld,
    input  pr_idx_t                 i_dealloc_prd_idx [COMMIT_WIDTH],

    output logic [RENAME_WIDTH-1:0] o_rename_fire,
    output pr_idx_t                 o_alloc_prd_idx [RENAME_WIDTH]
);

    // one extra wrap bit so a full ring differs from an empty one
    typedef logic [PR_W:0] ptr_t;

    pr_idx_t ring [NUM_PREGS];
    ptr_t    wr_ptr;
    ptr_t    spec_rd_ptr;
    ptr_t    arch_rd_ptr;

    ptr_t    free_cnt;
    ptr_t    need_cnt;
    ptr_t    commit_cnt;
    ptr_t    dealloc_cnt;
    ptr_t    lane_ofs [RENAME_WIDTH];
    ptr_t    dealloc_ofs [COMMIT_WIDTH];

    logic [RENAME_WIDTH-1:0] need_new;
    logic [COMMIT_WIDTH-1:0] commit_pop;
    logic                    grant;

    // moves and lanes without rd take nothing from the list
    assign need_new   = i_rename_vld & i_has_rd & ~i_ismv;
    assign commit_pop = i_commit_vld & i_commit_has_rd & ~i_commit_ismv;
    assign free_cnt   = wr_ptr - spec_rd_ptr;

    // prefix counts give each lane its slot past the read pointer
    always_comb begin
        need_cnt = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            lane_ofs[i] = need_cnt;
            need_cnt    = need_cnt + ptr_t'(need_new[i]);
        end
        commit_cnt = '0;
        dealloc_cnt = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_cnt     = commit_cnt + ptr_t'(commit_pop[i]);
            dealloc_ofs[i] = dealloc_cnt;
            dealloc_cnt    = dealloc_cnt + ptr_t'(i_dealloc_vld[i]);
        end
    end

    // whole group or nothing
    assign grant         = (free_cnt >= need_cnt) && !i_squash_vld;
    assign o_rename_fire = grant ? i_rename_vld : '0;

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            o_alloc_prd_idx[i] = ring[pr_idx_t'(spec_rd_ptr + lane_ofs[i])];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            // p1..p63 free, p0 stays with x0
            for (int i = 0; i < NUM_PREGS; i++) begin
                ring[i] <= pr_idx_t'(i + 1);
            end
            wr_ptr      <= ptr_t'(NUM_PREGS - 1);
            spec_rd_ptr <= '0;
            arch_rd_ptr <= '0;
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (i_dealloc_vld[i]) begin
                    ring[pr_idx_t'(wr_ptr + dealloc_ofs[i])] <= i_dealloc_prd_idx[i];
                end
            end
            wr_ptr      <= wr_ptr + dealloc_cnt;
            arch_rd_ptr <= arch_rd_ptr + commit_cnt;
            if (i_squash_vld) begin
                spec_rd_ptr <= arch_rd_ptr;
            end else if (grant) begin
                spec_rd_ptr <= spec_rd_ptr + need_cnt;
            end
        end
    end

endmodule

/* hw/rat_map.sv */
`timescale 1ns/10ps

module rat_map import rename_pkg::*; #(
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                    clk,
    input  logic                    i_rst,

    input  logic [RENAME_WIDTH-1:0] i_rename_fire,
    input  logic [RENAME_WIDTH-1:0] i_has_rd,
    input  logic [RENAME_WIDTH-1:0] i_ismv,
    input  lr_idx_t                 i_lrd_idx [RENAME_WIDTH],
    input  lr_idx_t                 i_lrs_idx [RENAME_WIDTH][NUM_SRCS],
    input  pr_idx_t                 i_alloc_prd_idx [RENAME_WIDTH],

    input  logic                    i_squash_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_has_rd,
    input  lr_idx_t                 i_commit_lrd_idx [COMMIT_WIDTH],
    input  pr_idx_t                 i_commit_prd_idx [COMMIT_WIDTH],

    output pr_idx_t                 o_renamed_prs_idx [RENAME_WIDTH][NUM_SRCS],
    output pr_idx_t                 o_renamed_prd_idx [RENAME_WIDTH],
    output logic [COMMIT_WIDTH-1:0] o_dealloc_vld,
    output pr_idx_t                 o_dealloc_prd_idx [COMMIT_WIDTH]
);

    pr_idx_t spec_map [NUM_LREGS];
    pr_idx_t arch_map [NUM_LREGS];

    pr_idx_t prs [RENAME_WIDTH][NUM_SRCS];
    pr_idx_t prd [RENAME_WIDTH];
    logic [RENAME_WIDTH-1:0] dst_wr;
    logic [COMMIT_WIDTH-1:0] commit_wr;

    // commit pipeline
    pr_idx_t prev_prd [COMMIT_WIDTH];
    pr_idx_t prev_prd_q [COMMIT_WIDTH];
    logic [COMMIT_WIDTH-1:0] prev_vld_q;
    logic [COMMIT_WIDTH-1:0] in_arch;
    logic [COMMIT_WIDTH-1:0] dup;
    logic [COMMIT_WIDTH-1:0] free_ok;
    logic [COMMIT_WIDTH-1:0] dealloc_vld_q;
    pr_idx_t dealloc_prd_q [COMMIT_WIDTH];

    // x0 never remapped
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            dst_wr[i] = i_rename_fire[i] && i_has_rd[i] && (i_lrd_idx[i] != '0);
        end
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_wr[i] = i_commit_vld[i] && i_commit_has_rd[i]
                           && (i_commit_lrd_idx[i] != '0);
        end
    end

    // source lookup, younger lanes see older rd of the same group
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            for (int s = 0; s < NUM_SRCS; s++) begin
                prs[i][s] = spec_map[i_lrs_idx[i][s]];
                for (int k = 0; k < i; k++) begin
                    if (dst_wr[k] && (i_lrs_idx[i][s] == i_lrd_idx[k])) begin
                        prs[i][s] = prd[k];
                    end
                end
            end
            if (!i_has_rd[i]) begin
                prd[i] = '0;
            end else if (i_ismv[i]) begin
                // mv rd,rs shares rs's register
                prd[i] = prs[i][0];
            end else begin
                prd[i] = i_alloc_prd_idx[i];
            end
        end
    end

    assign o_renamed_prs_idx = prs;
    assign o_renamed_prd_idx = prd;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_LREGS; i++) begin
                spec_map[i] <= '0;
            end
        end else if (i_squash_vld) begin
            spec_map <= arch_map;
        end else begin
            // youngest lane wins on same rd
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (dst_wr[i]) begin
                    spec_map[i_lrd_idx[i]] <= prd[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_LREGS; i++) begin
                arch_map[i] <= '0;
            end
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (commit_wr[i]) begin
                    arch_map[i_commit_lrd_idx[i]] <= i_commit_prd_idx[i];
                end
            end
        end
    end

    // stage 1: mapping each committed rd replaces
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            prev_prd[i] = commit_wr[i] ? arch_map[i_commit_lrd_idx[i]] : '0;
            for (int k = 0; k < i; k++) begin
                if (commit_wr[i] && commit_wr[k]
                    && (i_commit_lrd_idx[i] == i_commit_lrd_idx[k])) begin
                    prev_prd[i] = i_commit_prd_idx[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            prev_vld_q <= '0;
        end else begin
            prev_vld_q <= commit_wr;
        end
        prev_prd_q <= prev_prd;
    end

    // stage 2: release unless still architecturally mapped or repeated
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            in_arch[i] = 1'b0;
            dup[i]     = 1'b0;
            for (int l = 1; l < NUM_LREGS; l++) begin
                if (arch_map[l] == prev_prd_q[i]) begin
                    in_arch[i] = 1'b1;
                end
            end
            for (int k = 0; k < i; k++) begin
                if (prev_vld_q[k] && (prev_prd_q[k] == prev_prd_q[i])) begin
                    dup[i] = 1'b1;
                end
            end
            free_ok[i] = prev_vld_q[i] && (prev_prd_q[i] != '0) && !in_arch[i] && !dup[i];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            dealloc_vld_q <= '0;
        end else begin
            dealloc_vld_q <= free_ok;
        end
        dealloc_prd_q <= prev_prd_q;
    end

    assign o_dealloc_vld     = dealloc_vld_q;
    assign o_dealloc_prd_idx = dealloc_prd_q;

endmodule

/* hw/rename_pkg.sv */
package rename_pkg;

    // logical register file, x0 hardwired to physical 0
    localparam int NUM_LREGS = 32;
    localparam int LR_W      = $clog2(NUM_LREGS);

    // physical register file shared by the free list and both maps
    localparam int NUM_PREGS = 64;
    localparam int PR_W      = $clog2(NUM_PREGS);

    // source operands per instruction
    localparam int NUM_SRCS  = 2;

    typedef logic [LR_W-1:0] lr_idx_t;
    typedef logic [PR_W-1:0] pr_idx_t;

endpackage

/* hw/rename_unit.sv */
`timescale 1ns/10ps

module rename_unit import rename_pkg::*; #(
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                    clk,
    input  logic                    i_rst,

    // rename group
    input  logic [RENAME_WIDTH-1:0] i_rename_vld,
    input  logic [RENAME_WIDTH-1:0] i_has_rd,
    input  logic [RENAME_WIDTH-1:0] i_ismv,
    input  lr_idx_t                 i_lrd_idx [RENAME_WIDTH],
    input  lr_idx_t                 i_lrs_idx [RENAME_WIDTH][NUM_SRCS],
    output logic [RENAME_WIDTH-1:0] o_rename_fire,
    output pr_idx_t                 o_renamed_prs_idx [RENAME_WIDTH][NUM_SRCS],
    output pr_idx_t                 o_renamed_prd_idx [RENAME_WIDTH],

    // retire side
    input  logic                    i_squash_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_has_rd,
    input  logic [COMMIT_WIDTH-1:0] i_commit_ismv,
    input  lr_idx_t                 i_commit_lrd_idx [COMMIT_WIDTH],
    input  pr_idx_t                 i_commit_prd_idx [COMMIT_WIDTH],
    output logic [COMMIT_WIDTH-1:0] o_dealloc_vld,
    output pr_idx_t                 o_dealloc_prd_idx [COMMIT_WIDTH]
);

    pr_idx_t alloc_prd_idx [RENAME_WIDTH];

    free_list #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_free_list (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_rename_vld      (i_rename_vld),
        .i_has_rd          (i_has_rd),
        .i_ismv            (i_ismv),
        .i_squash_vld      (i_squash_vld),
        .i_commit_vld      (i_commit_vld),
        .i_commit_has_rd   (i_commit_has_rd),
        .i_commit_ismv     (i_commit_ismv),
        .i_dealloc_vld     (o_dealloc_vld),
        .i_dealloc_prd_idx (o_dealloc_prd_idx),
        .o_rename_fire     (o_rename_fire),
        .o_alloc_prd_idx   (alloc_prd_idx)
    );

    rat_map #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_rat_map (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_rename_fire     (o_rename_fire),
        .i_has_rd          (i_has_rd),
        .i_ismv            (i_ismv),
        .i_lrd_idx         (i_lrd_idx),
        .i_lrs_idx         (i_lrs_idx),
        .i_alloc_prd_idx   (alloc_prd_idx),
        .i_squash_vld      (i_squash_vld),
        .i_commit_vld      (i_commit_vld),
        .i_commit_has_rd   (i_commit_has_rd),
        .i_commit_lrd_idx  (i_commit_lrd_idx),
        .i_commit_prd_idx  (i_commit_prd_idx),
        .o_renamed_prs_idx (o_renamed_prs_idx),
        .o_renamed_prd_idx (o_renamed_prd_idx),
        .o_dealloc_vld     (o_dealloc_vld),
        .o_dealloc_prd_idx (o_dealloc_prd_idx)
    );

endmodule

/* rename.f */
hw/rename_pkg.sv
hw/free_list.sv
hw/rat_map.sv
hw/rename_unit.sv
testbench/tb_clock.sv
testbench/rename_sva.sv
testbench/rename_checker.sv
testbench/rename_tb.sv

/* testbench/rename_checker.sv */
`timescale 1ns/10ps

module rename_checker import rename_pkg::*; #(
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                    clk,
    input  logic                    i_rst,
    input  int                      i_test,
    input  logic                    i_done,
    input  logic [RENAME_WIDTH-1:0] i_rename_vld,
    input  logic [RENAME_WIDTH-1:0] i_has_rd,
    input  logic [RENAME_WIDTH-1:0] i_ismv,
    input  lr_idx_t                 i_lrd_idx [RENAME_WIDTH],
    input  lr_idx_t                 i_lrs_idx [RENAME_WIDTH][NUM_SRCS],
    input  logic                    i_squash_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_has_rd,
    input  logic [COMMIT_WIDTH-1:0] i_commit_ismv,
    input  lr_idx_t                 i_commit_lrd_idx [COMMIT_WIDTH],
    input  pr_idx_t                 i_commit_prd_idx [COMMIT_WIDTH],
    input  logic [RENAME_WIDTH-1:0] i_fire,
    input  pr_idx_t                 i_prs [RENAME_WIDTH][NUM_SRCS],
    input  pr_idx_t                 i_prd [RENAME_WIDTH],
    input  logic [COMMIT_WIDTH-1:0] i_dealloc_vld,
    input  pr_idx_t                 i_dealloc_prd [COMMIT_WIDTH],
    output int                      o_err_cnt
);

    pr_idx_t spec [NUM_LREGS];
    pr_idx_t arch [NUM_LREGS];
    pr_idx_t ring [NUM_PREGS];
    int      wr_ptr;
    int      spec_ptr;
    int      arch_ptr;

    // commit pipeline of the model
    logic [COMMIT_WIDTH-1:0] pend_vld;
    pr_idx_t                 pend_prd [COMMIT_WIDTH];
    logic [COMMIT_WIDTH-1:0] exp_vld;
    pr_idx_t                 exp_prd [COMMIT_WIDTH];

    // renamed destinations, replayed as commits by the testbench
    lr_idx_t rec_lrd [1024];
    pr_idx_t rec_prd [1024];
    logic    rec_mv [1024];
    int      rec_n = 0;

    int   err_cnt = 0;
    int   test_err = 0;
    int   checks = 0;
    int   cur_test = 0;
    logic done_seen = 1'b0;

    assign o_err_cnt = err_cnt;

    task automatic check_value(input string name, input int lane, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("MISMATCH %s lane %0d: got 0x%0h expected 0x%0h", name, lane, got, exp);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic end_test();
        $display("test %0d %s (%0d mismatches)", cur_test, (test_err == 0) ? "ok" : "failed",
                 test_err);
        test_err = 0;
    endtask

    always @(posedge clk) begin : model
        int need;
        int ofs;
        int pops;
        logic grant;
        logic hit;
        logic [RENAME_WIDTH-1:0] efire;
        logic [COMMIT_WIDTH-1:0] cwr;
        pr_idx_t eprs [RENAME_WIDTH][NUM_SRCS];
        pr_idx_t eprd [RENAME_WIDTH];
        pr_idx_t prev [COMMIT_WIDTH];
        if (i_rst) begin
            for (int l = 0; l < NUM_LREGS; l++) begin
                spec[l] = '0;
                arch[l] = '0;
            end
            for (int i = 0; i < NUM_PREGS; i++) begin
                ring[i] = pr_idx_t'(i + 1);
            end
            wr_ptr   = NUM_PREGS - 1;
            spec_ptr = 0;
            arch_ptr = 0;
            pend_vld = '0;
            exp_vld  = '0;
        end else begin
            if (i_test != cur_test) begin
                if (cur_test != 0) begin
                    end_test();
                end
                cur_test = i_test;
            end

            // group grant, all lanes or none
            need = 0;
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (i_rename_vld[i] && i_has_rd[i] && !i_ismv[i]) begin
                    need++;
                end
            end
            grant = (wr_ptr - spec_ptr >= need) && !i_squash_vld;
            efire = grant ? i_rename_vld : '0;
            check_value("o_rename_fire", 0, int'(i_fire), int'(efire));

            ofs = 0;
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                for (int s = 0; s < NUM_SRCS; s++) begin
                    eprs[i][s] = spec[i_lrs_idx[i][s]];
                    for (int k = 0; k < i; k++) begin
                        if (efire[k] && i_has_rd[k] && (i_lrd_idx[k] != '0)
                            && (i_lrd_idx[k] == i_lrs_idx[i][s])) begin
                            eprs[i][s] = eprd[k];
                        end
                    end
                end
                if (!i_has_rd[i]) begin
                    eprd[i] = '0;
                end else if (i_ismv[i]) begin
                    eprd[i] = eprs[i][0];
                end else begin
                    eprd[i] = ring[pr_idx_t'(spec_ptr + ofs)];
                    if (i_rename_vld[i]) begin
                        ofs++;
                    end
                end
                if (i_rename_vld[i]) begin
                    for (int s = 0; s < NUM_SRCS; s++) begin
                        check_value("o_renamed_prs_idx", i, int'(i_prs[i][s]),
                                    int'(eprs[i][s]));
                    end
                    check_value("o_renamed_prd_idx", i, int'(i_prd[i]), int'(eprd[i]));
                end
            end

            // releases due this cycle go to the tail
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                check_value("o_dealloc_vld", c, int'(i_dealloc_vld[c]), int'(exp_vld[c]));
                if (exp_vld[c]) begin
                    check_value("o_dealloc_prd_idx", c, int'(i_dealloc_prd[c]),
                                int'(exp_prd[c]));
                    ring[pr_idx_t'(wr_ptr)] = exp_prd[c];
                    wr_ptr++;
                end
            end

            // second commit stage against the current architectural map
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                hit = 1'b0;
                for (int l = 1; l < NUM_LREGS; l++) begin
                    if (arch[l] == pend_prd[c]) begin
                        hit = 1'b1;
                    end
                end
                for (int k = 0; k < c; k++) begin
                    if (pend_vld[k] && (pend_prd[k] == pend_prd[c])) begin
                        hit = 1'b1;
                    end
                end
                exp_vld[c] = pend_vld[c] && (pend_prd[c] != '0) && !hit;
                exp_prd[c] = pend_prd[c];
            end

            // first commit stage, previous mapping of each destination
            pops = 0;
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                cwr[c] = i_commit_vld[c] && i_commit_has_rd[c] && (i_commit_lrd_idx[c] != '0);
                prev[c] = cwr[c] ? arch[i_commit_lrd_idx[c]] : '0;
                for (int k = 0; k < c; k++) begin
                    if (cwr[c] && cwr[k] && (i_commit_lrd_idx[k] == i_commit_lrd_idx[c])) begin
                        prev[c] = i_commit_prd_idx[k];
                    end
                end
                if (i_commit_vld[c] && i_commit_has_rd[c] && !i_commit_ismv[c]) begin
                    pops++;
                end
            end
            pend_vld = cwr;
            pend_prd = prev;

            // squash copies the map and pointer as they were before this commit
            if (i_squash_vld) begin
                spec     = arch;
                spec_ptr = arch_ptr;
            end else if (grant) begin
                for (int i = 0; i < RENAME_WIDTH; i++) begin
                    if (efire[i] && i_has_rd[i]) begin
                        if (i_lrd_idx[i] != '0) begin
                            spec[i_lrd_idx[i]] = eprd[i];
                        end
                        rec_lrd[rec_n] = i_lrd_idx[i];
                        rec_prd[rec_n] = eprd[i];
                        rec_mv[rec_n]  = i_ismv[i];
                        rec_n++;
                    end
                end
                spec_ptr = spec_ptr + need;
            end

            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (cwr[c]) begin
                    arch[i_commit_lrd_idx[c]] = i_commit_prd_idx[c];
                end
            end
            arch_ptr = arch_ptr + pops;

            if (i_done && !done_seen) begin
                end_test();
                $display("%0d tests, %0d checks, %0d errors", cur_test, checks, err_cnt);
                done_seen = 1'b1;
            end
        end
    end

endmodule

/* testbench/rename_sva.sv */
`timescale 1ns/10ps

module rename_sva import rename_pkg::*; #(
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input logic                    clk,
    input logic                    i_rst,
    input lr_idx_t                 i_lrs_idx [RENAME_WIDTH][NUM_SRCS],
    input pr_idx_t                 o_renamed_prs_idx [RENAME_WIDTH][NUM_SRCS],
    input logic [COMMIT_WIDTH-1:0] o_dealloc_vld,
    input pr_idx_t                 o_dealloc_prd_idx [COMMIT_WIDTH]
);

    for (genvar l = 0; l < RENAME_WIDTH; l++) begin : g_lane
        for (genvar s = 0; s < NUM_SRCS; s++) begin : g_src
            assert property (@(posedge clk) disable iff (i_rst)
                (i_lrs_idx[l][s] == '0) |-> (o_renamed_prs_idx[l][s] == '0))
                else $error("x0 source renamed to a nonzero physical register");
        end
    end

    for (genvar c = 0; c < COMMIT_WIDTH; c++) begin : g_dealloc
        assert property (@(posedge clk) disable iff (i_rst)
            o_dealloc_vld[c] |-> (o_dealloc_prd_idx[c] != '0))
            else $error("physical register 0 released to the free list");
    end

    assert property (@(posedge clk) (i_rst && $past(i_rst)) |-> (o_dealloc_vld == '0))
        else $error("dealloc valid during reset");

endmodule

bind rename_unit rename_sva #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
) u_sva (.*);

/* testbench/rename_tb.sv */
`timescale 1ns/10ps

module rename_tb import rename_pkg::*; ();

    localparam int NUM_ROWS = 20;
    localparam int NUM_RAND = 40;

    typedef struct packed {
        logic [7:0] test;
        logic [7:0] rep;
        logic [1:0] vld;
        logic [1:0] rd;
        logic [1:0] mv;
        lr_idx_t    lrd0;
        lr_idx_t    lrd1;
        lr_idx_t    s00;
        lr_idx_t    s01;
        lr_idx_t    s10;
        lr_idx_t    s11;
        logic [1:0] ccnt;
        logic       sq;
    } row_t;

    logic       clk;
    logic       rst;
    logic [1:0] rename_vld;
    logic [1:0] has_rd;
    logic [1:0] ismv;
    lr_idx_t    lrd_idx [2];
    lr_idx_t    lrs_idx [2][NUM_SRCS];
    logic       squash_vld;
    logic [1:0] commit_vld;
    logic [1:0] commit_has_rd;
    logic [1:0] commit_ismv;
    lr_idx_t    commit_lrd_idx [2];
    pr_idx_t    commit_prd_idx [2];
    logic [1:0] rename_fire;
    pr_idx_t    renamed_prs_idx [2][NUM_SRCS];
    pr_idx_t    renamed_prd_idx [2];
    logic [1:0] dealloc_vld;
    pr_idx_t    dealloc_prd_idx [2];

    row_t        rows [NUM_ROWS];
    row_t        rnd_row;
    int          test_id;
    logic        done;
    int          err_cnt;
    int          cidx;
    logic        resync;
    int          cycles;
    int          limit;
    logic [31:0] rnd;

    tb_clock u_clock (.clk(clk), .o_rst(rst));

    rename_unit #(.RENAME_WIDTH(2), .COMMIT_WIDTH(2)) dut (
        .clk(clk), .i_rst(rst),
        .i_rename_vld(rename_vld), .i_has_rd(has_rd), .i_ismv(ismv),
        .i_lrd_idx(lrd_idx), .i_lrs_idx(lrs_idx), .o_rename_fire(rename_fire),
        .o_renamed_prs_idx(renamed_prs_idx), .o_renamed_prd_idx(renamed_prd_idx),
        .i_squash_vld(squash_vld), .i_commit_vld(commit_vld),
        .i_commit_has_rd(commit_has_rd), .i_commit_ismv(commit_ismv),
        .i_commit_lrd_idx(commit_lrd_idx), .i_commit_prd_idx(commit_prd_idx),
        .o_dealloc_vld(dealloc_vld), .o_dealloc_prd_idx(dealloc_prd_idx)
    );

    rename_checker #(.RENAME_WIDTH(2), .COMMIT_WIDTH(2)) chk (
        .clk(clk), .i_rst(rst), .i_test(test_id), .i_done(done),
        .i_rename_vld(rename_vld), .i_has_rd(has_rd), .i_ismv(ismv),
        .i_lrd_idx(lrd_idx), .i_lrs_idx(lrs_idx), .i_squash_vld(squash_vld),
        .i_commit_vld(commit_vld), .i_commit_has_rd(commit_has_rd),
        .i_commit_ismv(commit_ismv), .i_commit_lrd_idx(commit_lrd_idx),
        .i_commit_prd_idx(commit_prd_idx), .i_fire(rename_fire),
        .i_prs(renamed_prs_idx), .i_prd(renamed_prd_idx),
        .i_dealloc_vld(dealloc_vld), .i_dealloc_prd(dealloc_prd_idx),
        .o_err_cnt(err_cnt)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic row_t make_row(input int test, input int rep, input int vld,
                                      input int rd, input int mv, input int lrd0,
                                      input int lrd1, input int s00, input int s01,
                                      input int s10, input int s11, input int ccnt,
                                      input int sq);
        row_t r;
        r.test = 8'(test);
        r.rep  = 8'(rep);
        r.vld  = 2'(vld);
        r.rd   = 2'(rd);
        r.mv   = 2'(mv);
        r.lrd0 = lr_idx_t'(lrd0);
        r.lrd1 = lr_idx_t'(lrd1);
        r.s00  = lr_idx_t'(s00);
        r.s01  = lr_idx_t'(s01);
        r.s10  = lr_idx_t'(s10);
        r.s11  = lr_idx_t'(s11);
        r.ccnt = 2'(ccnt);
        r.sq   = sq[0];
        return r;
    endfunction

    // commits come from the checker's record of renamed destinations, oldest first
    task automatic apply_row(input row_t r);
        logic [1:0] cv;
        logic [1:0] cm;
        lr_idx_t    cl [2];
        pr_idx_t    cp [2];
        @(negedge clk);
        if (resync) begin
            cidx = chk.rec_n;
        end
        resync = r.sq;
        cv = '0;
        cm = '0;
        for (int l = 0; l < 2; l++) begin
            cl[l] = '0;
            cp[l] = '0;
            if (l < int'(r.ccnt) && cidx < chk.rec_n) begin
                cv[l] = 1'b1;
                cm[l] = chk.rec_mv[cidx];
                cl[l] = chk.rec_lrd[cidx];
                cp[l] = chk.rec_prd[cidx];
                cidx++;
            end
        end
        @(posedge clk);
        test_id        <= int'(r.test);
        rename_vld     <= r.vld;
        has_rd         <= r.rd;
        ismv           <= r.mv;
        lrd_idx[0]     <= r.lrd0;
        lrd_idx[1]     <= r.lrd1;
        lrs_idx[0][0]  <= r.s00;
        lrs_idx[0][1]  <= r.s01;
        lrs_idx[1][0]  <= r.s10;
        lrs_idx[1][1]  <= r.s11;
        squash_vld     <= r.sq;
        commit_vld     <= cv;
        commit_has_rd  <= cv;
        commit_ismv    <= cm;
        commit_lrd_idx <= cl;
        commit_prd_idx <= cp;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        rename_vld = '0;
        has_rd = '0;
        ismv = '0;
        lrd_idx = '{default: '0};
        lrs_idx = '{default: '{default: '0}};
        squash_vld = 1'b0;
        commit_vld = '0;
        commit_has_rd = '0;
        commit_ismv = '0;
        commit_lrd_idx = '{default: '0};
        commit_prd_idx = '{default: '0};
        test_id = 0;
        done = 1'b0;
        cidx = 0;
        resync = 1'b0;
        cycles = 0;
        rnd = 32'd74;

        //                 test rep vld rd mv lrd0 lrd1 s00 s01 s10 s11 ccnt sq
        rows[0]  = make_row(1, 1, 3, 3, 0, 1, 2, 0, 0, 3, 4, 0, 0);
        rows[1]  = make_row(1, 1, 3, 3, 0, 3, 4, 5, 6, 7, 8, 0, 0);
        rows[2]  = make_row(2, 1, 3, 3, 0, 5, 6, 1, 2, 5, 1, 0, 0);
        rows[3]  = make_row(2, 1, 1, 0, 0, 0, 0, 5, 6, 0, 0, 0, 0);
        rows[4]  = make_row(3, 1, 3, 3, 1, 7, 8, 1, 0, 7, 0, 0, 0);
        rows[5]  = make_row(3, 1, 1, 1, 0, 9, 0, 8, 7, 0, 0, 0, 0);
        rows[6]  = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0);
        rows[7]  = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0);
        rows[8]  = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0);
        rows[9]  = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0);
        rows[10] = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0);
        // x10 and x11 both alias p2, then x2, x10 and x11 are redefined
        rows[11] = make_row(4, 1, 3, 3, 3, 10, 11, 2, 0, 2, 0, 0, 0);
        rows[12] = make_row(4, 1, 3, 3, 0, 2, 1, 0, 0, 0, 0, 2, 0);
        rows[13] = make_row(4, 1, 3, 3, 0, 10, 11, 0, 0, 0, 0, 2, 0);
        rows[14] = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0);
        // x10 and x11 retire together, p2 goes back once
        rows[15] = make_row(4, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0);
        rows[16] = make_row(5, 1, 3, 3, 0, 12, 13, 0, 0, 0, 0, 0, 0);
        rows[17] = make_row(5, 1, 3, 3, 0, 16, 17, 1, 2, 3, 4, 0, 1);
        rows[18] = make_row(5, 1, 3, 3, 0, 14, 15, 1, 2, 12, 13, 0, 0);
        rows[19] = make_row(6, 32, 3, 3, 0, 20, 21, 20, 21, 20, 21, 0, 0);

        limit = NUM_RAND + 20;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit = limit + int'(rows[i].rep);
        end

        while (rst) begin
            @(negedge clk);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int n = 0; n < int'(rows[i].rep); n++) begin
                apply_row(rows[i]);
            end
        end

        for (int n = 0; n < NUM_RAND; n++) begin
            rnd = next_random(rnd);
            rnd_row = make_row(7, 1, int'(rnd[1:0]), int'(rnd[3:2]), int'(rnd[5:4]),
                               int'(rnd[10:6]), int'(rnd[15:11]), int'(rnd[20:16]),
                               int'(rnd[25:21]), int'(rnd[30:26]), 0, 0, 0);
            rnd = next_random(rnd);
            rnd_row.s11 = rnd[4:0];
            rnd_row.ccnt = 2'(rnd[7:5] % 3'd3);
            apply_row(rnd_row);
        end
        // idle rows let the last releases drain
        for (int n = 0; n < 3; n++) begin
            apply_row(make_row(7, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
        end

        @(negedge clk);
        done = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic o_rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over the first 4 rising edges
    initial begin
        o_rst = 1'b1;
        repeat (4) @(posedge clk);
        o_rst <= 1'b0;
    end

endmodule
